//--- cpu_consts.svh
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// core-wide sizes

// datapath and instruction word
`define CPU_DATA_W 16

// imem and dmem address width
`define CPU_ADDR_W 16

// general registers r0..r7
`define CPU_REG_CNT 8

`endif

//--- isa_pkg.sv
package isa_pkg;

	`include "cpu_consts.svh"

	// machine word, used for both data and instructions
	typedef logic [`CPU_DATA_W-1:0] word_t;
	typedef logic [`CPU_ADDR_W-1:0] addr_t;
	typedef logic [$clog2(`CPU_REG_CNT)-1:0] reg_idx_t;

	// major opcode, instr[15:11]
	typedef enum logic [4:0] {
		OP_NOP   = 5'b00001,
		OP_B     = 5'b00010,
		OP_BEQZ  = 5'b00100,
		OP_ADDIU = 5'b01001,
		OP_LW    = 5'b10011,
		OP_SW    = 5'b11011,
		OP_RRR   = 5'b11100,
		OP_ALU   = 5'b11101
	} opcode_t;

	// field positions
	localparam int OPC_MSB = 15;
	localparam int OPC_LSB = 11;
	localparam int RX_LSB  = 8;
	localparam int RY_LSB  = 5;
	localparam int RZ_LSB  = 2;
	localparam int IMM5_W  = 5;
	localparam int IMM8_W  = 8;
	localparam int OFF11_W = 11;

	// function codes, RRR in bits 1:0 and ALU in bits 4:0
	localparam logic [1:0] FN_ADDU = 2'b01;
	localparam logic [1:0] FN_SUBU = 2'b11;
	localparam logic [4:0] FN_AND  = 5'b01100;
	localparam logic [4:0] FN_OR   = 5'b01101;

endpackage

//--- pipe_pkg.sv
package pipe_pkg;

	`include "cpu_consts.svh"

	// zero encodings are picked so an all-zero payload is a bubble
	typedef enum logic [2:0] {
		ALU_ADD    = 3'd0,
		ALU_SUB    = 3'd1,
		ALU_AND    = 3'd2,
		ALU_OR     = 3'd3,
		ALU_PASS_B = 3'd4
	} alu_op_t;

	// operand source in execute
	typedef enum logic [1:0] {
		FWD_REG   = 2'd0,
		FWD_EXMEM = 2'd1,
		FWD_MEMWB = 2'd2
	} fwd_sel_t;

	typedef enum logic [1:0] {
		BR_NONE   = 2'd0,
		BR_ZERO   = 2'd1,
		BR_ALWAYS = 2'd2
	} br_kind_t;

	////////////////////////////////////////////////////////////////////////////
	// stage payloads

	typedef struct packed {
		isa_pkg::word_t instr;
		isa_pkg::word_t pc_plus1;
	} ifid_t;

	typedef struct packed {
		isa_pkg::word_t    rdata1;
		isa_pkg::word_t    rdata2;
		isa_pkg::reg_idx_t rs1;
		isa_pkg::reg_idx_t rs2;
		isa_pkg::reg_idx_t rd;
		isa_pkg::word_t    imm;
		alu_op_t           alu_op;
		logic              src_b_imm;
		logic              reg_write;
		logic              mem_read;
		logic              mem_write;
		br_kind_t          br_kind;
		isa_pkg::word_t    br_target;
	} idex_t;

	typedef struct packed {
		isa_pkg::word_t    alu_res;
		isa_pkg::word_t    store_data;
		isa_pkg::reg_idx_t rd;
		logic              reg_write;
		logic              mem_read;
		logic              mem_write;
	} exmem_t;

	typedef struct packed {
		isa_pkg::word_t    alu_res;
		isa_pkg::word_t    load_data;
		isa_pkg::reg_idx_t rd;
		logic              reg_write;
		logic              mem_to_reg;
	} memwb_t;

endpackage

//--- pipe_reg.sv
`timescale 1ns/1ps

module pipe_reg #(
	parameter type payload_t = logic
) (
	input  logic     clk,
	input  logic     reset_i,
	// freeze current contents
	input  logic     hold_i,
	// squash, loads a bubble
	input  logic     flush_i,
	input  payload_t d_i,
	output payload_t q_o
);

	// flush beats hold
	// a stalled stage that also gets squashed must not keep its old payload
	always_ff @(posedge clk) begin
		if (reset_i || flush_i) begin
			q_o <= '0;
		end else if (!hold_i) begin
			q_o <= d_i;
		end
	end

endmodule

//--- fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit (
	input  logic           clk,
	input  logic           reset_i,
	// load-use stall
	input  logic           hold_i,
	// taken branch from execute
	input  logic           redirect_i,
	input  isa_pkg::word_t redirect_pc_i,
	output isa_pkg::word_t imem_addr_o,
	output isa_pkg::word_t pc_plus1_o
);

	import isa_pkg::*;

	addr_t pc_q;

	// next pc
	// redirect first, then hold, else sequential
	always_ff @(posedge clk) begin
		if (reset_i) begin
			pc_q <= '0;
		end else if (redirect_i) begin
			pc_q <= redirect_pc_i;
		end else if (!hold_i) begin
			pc_q <= pc_q + addr_t'(1);
		end
	end

	// imem answers in the same cycle
	assign imem_addr_o = pc_q;

	// travels with the instruction for branch targets
	assign pc_plus1_o = pc_q + addr_t'(1);

endmodule

//--- decode_unit.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module decode_unit (
	input  isa_pkg::word_t    instr_i,
	input  isa_pkg::word_t    pc_plus1_i,
	output isa_pkg::reg_idx_t rs1_o,
	output isa_pkg::reg_idx_t rs2_o,
	input  isa_pkg::word_t    rdata1_i,
	input  isa_pkg::word_t    rdata2_i,
	output pipe_pkg::idex_t   idex_o
);

	import isa_pkg::*;
	import pipe_pkg::*;

	opcode_t  opcode;
	reg_idx_t rx;
	reg_idx_t ry;
	reg_idx_t rz;
	word_t    imm5;
	word_t    imm8;
	word_t    off11;
	logic     read_a;
	logic     read_b;

	////////////////////////////////////////////////////////////////////////////
	// field split

	assign opcode = opcode_t'(instr_i[OPC_MSB:OPC_LSB]);
	assign rx     = instr_i[RX_LSB +: $bits(reg_idx_t)];
	assign ry     = instr_i[RY_LSB +: $bits(reg_idx_t)];
	assign rz     = instr_i[RZ_LSB +: $bits(reg_idx_t)];

	// sign extension, imm8 doubles as the beqz offset
	assign imm5  = {{(`CPU_DATA_W-IMM5_W){instr_i[IMM5_W-1]}}, instr_i[IMM5_W-1:0]};
	assign imm8  = {{(`CPU_DATA_W-IMM8_W){instr_i[IMM8_W-1]}}, instr_i[IMM8_W-1:0]};
	assign off11 = {{(`CPU_DATA_W-OFF11_W){instr_i[OFF11_W-1]}}, instr_i[OFF11_W-1:0]};

	// register file is always asked for rx and ry
	assign rs1_o = rx;
	assign rs2_o = ry;

	////////////////////////////////////////////////////////////////////////////
	// control fields

	always_comb begin
		idex_o = '0;
		read_a = 1'b0;
		read_b = 1'b0;
		case (opcode)
			OP_B, OP_BEQZ: begin
				read_a           = (opcode == OP_BEQZ);
				idex_o.br_kind   = (opcode == OP_BEQZ) ? BR_ZERO : BR_ALWAYS;
				idex_o.imm       = (opcode == OP_BEQZ) ? imm8 : off11;
				idex_o.br_target = pc_plus1_i + idex_o.imm;
				idex_o.alu_op    = ALU_PASS_B;
				idex_o.src_b_imm = 1'b1;
			end
			OP_ADDIU: begin
				read_a           = 1'b1;
				idex_o.rd        = rx;
				idex_o.imm       = imm8;
				idex_o.src_b_imm = 1'b1;
				idex_o.reg_write = 1'b1;
			end
			OP_LW, OP_SW: begin
				// address is rx + imm5 through the adder
				read_a           = 1'b1;
				read_b           = (opcode == OP_SW);
				idex_o.rd        = ry;
				idex_o.imm       = imm5;
				idex_o.src_b_imm = 1'b1;
				idex_o.reg_write = (opcode == OP_LW);
				idex_o.mem_read  = (opcode == OP_LW);
				idex_o.mem_write = (opcode == OP_SW);
			end
			OP_RRR: begin
				if (instr_i[1:0] == FN_ADDU || instr_i[1:0] == FN_SUBU) begin
					read_a           = 1'b1;
					read_b           = 1'b1;
					idex_o.rd        = rz;
					idex_o.alu_op    = (instr_i[1:0] == FN_SUBU) ? ALU_SUB : ALU_ADD;
					idex_o.reg_write = 1'b1;
				end
			end
			OP_ALU: begin
				if (instr_i[4:0] == FN_AND || instr_i[4:0] == FN_OR) begin
					read_a           = 1'b1;
					read_b           = 1'b1;
					idex_o.rd        = rx;
					idex_o.alu_op    = (instr_i[4:0] == FN_OR) ? ALU_OR : ALU_AND;
					idex_o.reg_write = 1'b1;
				end
			end
			// nop and anything unknown stay a bubble
			OP_NOP: ;
			default: ;
		endcase
		if (read_a) begin
			idex_o.rs1    = rx;
			idex_o.rdata1 = rdata1_i;
		end
		if (read_b) begin
			idex_o.rs2    = ry;
			idex_o.rdata2 = rdata2_i;
		end
	end

endmodule

//--- reg_file.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module reg_file (
	input  logic              clk,
	input  logic              reset_i,
	input  isa_pkg::reg_idx_t rs1_i,
	input  isa_pkg::reg_idx_t rs2_i,
	output isa_pkg::word_t    rdata1_o,
	output isa_pkg::word_t    rdata2_o,
	input  pipe_pkg::memwb_t  memwb_i,
	// writeback value, also the memwb forwarding source
	output isa_pkg::word_t    wb_data_o
);

	import isa_pkg::*;

	word_t regs_q [`CPU_REG_CNT];

	// load data or alu result
	assign wb_data_o = memwb_i.mem_to_reg ? memwb_i.load_data : memwb_i.alu_res;

	always_ff @(posedge clk) begin
		if (reset_i) begin
			for (int i = 0; i < `CPU_REG_CNT; i++) begin
				regs_q[i] <= '0;
			end
		end else if (memwb_i.reg_write) begin
			regs_q[memwb_i.rd] <= wb_data_o;
		end
	end

	// write-through so decode sees this cycle's writeback
	assign rdata1_o = (memwb_i.reg_write && memwb_i.rd == rs1_i) ? wb_data_o : regs_q[rs1_i];
	assign rdata2_o = (memwb_i.reg_write && memwb_i.rd == rs2_i) ? wb_data_o : regs_q[rs2_i];

endmodule

//--- execute_unit.sv
`timescale 1ns/1ps

module execute_unit (
	input  pipe_pkg::idex_t   idex_i,
	input  pipe_pkg::exmem_t  exmem_i,
	input  isa_pkg::word_t    wb_data_i,
	input  isa_pkg::reg_idx_t wb_dst_i,
	input  logic              wb_we_i,
	output pipe_pkg::exmem_t  exmem_o,
	output logic              branch_taken_o,
	output isa_pkg::word_t    branch_pc_o
);

	import isa_pkg::*;
	import pipe_pkg::*;

	fwd_sel_t sel_a;
	fwd_sel_t sel_b;
	word_t    op_a;
	word_t    op_b_reg;
	word_t    op_b;
	word_t    alu_res;
	logic     ex_fwd_ok;

	// youngest producer wins
	function automatic fwd_sel_t pick_src(input reg_idx_t src, input logic ex_ok,
			input reg_idx_t ex_rd, input logic wb_we, input reg_idx_t wb_rd);
		if (ex_ok && ex_rd == src) begin
			return FWD_EXMEM;
		end
		if (wb_we && wb_rd == src) begin
			return FWD_MEMWB;
		end
		return FWD_REG;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// forwarding

	// a load in ex/mem has no data yet, the stall covers that case
	assign ex_fwd_ok = exmem_i.reg_write & ~exmem_i.mem_read;

	assign sel_a = pick_src(idex_i.rs1, ex_fwd_ok, exmem_i.rd, wb_we_i, wb_dst_i);
	assign sel_b = pick_src(idex_i.rs2, ex_fwd_ok, exmem_i.rd, wb_we_i, wb_dst_i);

	assign op_a = (sel_a == FWD_EXMEM) ? exmem_i.alu_res :
	              (sel_a == FWD_MEMWB) ? wb_data_i : idex_i.rdata1;

	// forwarded rs2 is also the store data
	assign op_b_reg = (sel_b == FWD_EXMEM) ? exmem_i.alu_res :
	                  (sel_b == FWD_MEMWB) ? wb_data_i : idex_i.rdata2;

	assign op_b = idex_i.src_b_imm ? idex_i.imm : op_b_reg;

	////////////////////////////////////////////////////////////////////////////
	// alu and branch

	always_comb begin
		case (idex_i.alu_op)
			ALU_ADD:    alu_res = op_a + op_b;
			ALU_SUB:    alu_res = op_a - op_b;
			ALU_AND:    alu_res = op_a & op_b;
			ALU_OR:     alu_res = op_a | op_b;
			ALU_PASS_B: alu_res = op_b;
			default:    alu_res = '0;
		endcase
	end

	// beqz tests the forwarded rx
	assign branch_taken_o = (idex_i.br_kind == BR_ALWAYS) ||
	                        (idex_i.br_kind == BR_ZERO && op_a == '0);
	assign branch_pc_o    = idex_i.br_target;

	assign exmem_o.alu_res    = alu_res;
	assign exmem_o.store_data = op_b_reg;
	assign exmem_o.rd         = idex_i.rd;
	assign exmem_o.reg_write  = idex_i.reg_write;
	assign exmem_o.mem_read   = idex_i.mem_read;
	assign exmem_o.mem_write  = idex_i.mem_write;

endmodule

//--- hazard_unit.sv
`timescale 1ns/1ps

module hazard_unit (
	// decode sources
	input  isa_pkg::reg_idx_t rs1_i,
	input  isa_pkg::reg_idx_t rs2_i,
	// instruction now in execute
	input  isa_pkg::reg_idx_t ex_dst_i,
	input  logic              ex_memread_i,
	input  logic              branch_taken_i,
	output logic              stall_o,
	output logic              flush_ifid_o,
	output logic              flush_idex_o
);

	logic load_use;

	// load result not ready until its mem cycle
	// conservative, rx/ry are compared even when the op ignores them
	assign load_use = ex_memread_i && (ex_dst_i == rs1_i || ex_dst_i == rs2_i);

	// a taken branch squashes the dependent instruction anyway
	assign stall_o = load_use & ~branch_taken_i;

	// two wrong-path slots on a taken branch
	assign flush_ifid_o = branch_taken_i;

	// bubble into execute on a stall
	assign flush_idex_o = branch_taken_i | load_use;

endmodule

//--- cpu_core.sv
`timescale 1ns/1ps

module cpu_core (
	input  logic           clk,
	input  logic           reset_i,
	// instruction memory, same-cycle read
	output isa_pkg::word_t imem_addr_o,
	input  isa_pkg::word_t imem_data_i,
	// data memory, same-cycle read
	output isa_pkg::word_t dmem_addr_o,
	output isa_pkg::word_t dmem_wdata_o,
	output logic           dmem_we_o,
	output logic           dmem_re_o,
	input  isa_pkg::word_t dmem_rdata_i
);

	import isa_pkg::*;
	import pipe_pkg::*;

	word_t    pc_plus1;
	reg_idx_t rs1;
	reg_idx_t rs2;
	word_t    rdata1;
	word_t    rdata2;
	word_t    wb_data;
	word_t    branch_pc;
	logic     branch_taken;
	logic     stall;
	logic     flush_ifid;
	logic     flush_idex;

	ifid_t  ifid_d;
	ifid_t  ifid_q;
	idex_t  idex_d;
	idex_t  idex_q;
	exmem_t exmem_d;
	exmem_t exmem_q;
	memwb_t memwb_d;
	memwb_t memwb_q;

	////////////////////////////////////////////////////////////////////////////
	// fetch and decode

	fetch_unit fetch_inst (
		.clk(clk),
		.reset_i(reset_i),
		.hold_i(stall),
		.redirect_i(branch_taken),
		.redirect_pc_i(branch_pc),
		.imem_addr_o(imem_addr_o),
		.pc_plus1_o(pc_plus1)
	);

	assign ifid_d = '{instr: imem_data_i, pc_plus1: pc_plus1};

	pipe_reg #(.payload_t(ifid_t)) ifid_reg (
		.clk(clk), .reset_i(reset_i), .hold_i(stall), .flush_i(flush_ifid),
		.d_i(ifid_d), .q_o(ifid_q)
	);

	decode_unit decode_inst (
		.instr_i(ifid_q.instr),
		.pc_plus1_i(ifid_q.pc_plus1),
		.rs1_o(rs1),
		.rs2_o(rs2),
		.rdata1_i(rdata1),
		.rdata2_i(rdata2),
		.idex_o(idex_d)
	);

	reg_file rf_inst (
		.clk(clk), .reset_i(reset_i),
		.rs1_i(rs1), .rs2_i(rs2),
		.rdata1_o(rdata1), .rdata2_o(rdata2),
		.memwb_i(memwb_q), .wb_data_o(wb_data)
	);

	pipe_reg #(.payload_t(idex_t)) idex_reg (
		.clk(clk), .reset_i(reset_i), .hold_i(1'b0), .flush_i(flush_idex),
		.d_i(idex_d), .q_o(idex_q)
	);

	////////////////////////////////////////////////////////////////////////////
	// execute, memory, writeback

	execute_unit execute_inst (
		.idex_i(idex_q), .exmem_i(exmem_q),
		.wb_data_i(wb_data), .wb_dst_i(memwb_q.rd), .wb_we_i(memwb_q.reg_write),
		.exmem_o(exmem_d), .branch_taken_o(branch_taken), .branch_pc_o(branch_pc)
	);

	hazard_unit hazard_inst (
		.rs1_i(rs1), .rs2_i(rs2),
		.ex_dst_i(idex_q.rd), .ex_memread_i(idex_q.mem_read),
		.branch_taken_i(branch_taken),
		.stall_o(stall), .flush_ifid_o(flush_ifid), .flush_idex_o(flush_idex)
	);

	pipe_reg #(.payload_t(exmem_t)) exmem_reg (
		.clk(clk), .reset_i(reset_i), .hold_i(1'b0), .flush_i(1'b0),
		.d_i(exmem_d), .q_o(exmem_q)
	);

	// dmem straight off ex/mem, one strobe per store
	assign dmem_addr_o  = exmem_q.alu_res;
	assign dmem_wdata_o = exmem_q.store_data;
	assign dmem_we_o    = exmem_q.mem_write;
	assign dmem_re_o    = exmem_q.mem_read;

	assign memwb_d = '{alu_res: exmem_q.alu_res, load_data: dmem_rdata_i, rd: exmem_q.rd,
	                   reg_write: exmem_q.reg_write, mem_to_reg: exmem_q.mem_read};

	pipe_reg #(.payload_t(memwb_t)) memwb_reg (
		.clk(clk), .reset_i(reset_i), .hold_i(1'b0), .flush_i(1'b0),
		.d_i(memwb_d), .q_o(memwb_q)
	);

endmodule

//--- tb_cpu_core.sv
`timescale 1ns/1ps

module tb_cpu_core;

	import isa_pkg::*;

	localparam int MAX_TESTS   = 8;
	localparam int N_TESTS     = 6;
	localparam int PROG_WORDS  = 16;
	localparam int MAX_STORES  = 4;
	// each test gets 4 cycles per program word plus reset and drain slack
	localparam int CYCLE_LIMIT = N_TESTS * (4 * PROG_WORDS + 30);
	// quiet cycles after the last expected store
	localparam int DRAIN       = 8;
	localparam logic [15:0] NOP_WORD = 16'h0800;

	logic  clk = 1'b0;
	logic  reset_i;
	word_t imem_addr;
	word_t imem_data;
	word_t dmem_addr;
	word_t dmem_wdata;
	logic  dmem_we;
	logic  dmem_re;
	word_t dmem_rdata;

	// memory models
	logic [15:0] imem [PROG_WORDS];
	word_t       dmem [256];

	// test table of programs and expected stores in program order
	string test_name [MAX_TESTS];
	word_t prog      [MAX_TESTS][PROG_WORDS];
	int    prog_len  [MAX_TESTS];
	word_t exp_addr  [MAX_TESTS][MAX_STORES];
	word_t exp_data  [MAX_TESTS][MAX_STORES];
	int    exp_cnt   [MAX_TESTS];
	// dmem_re pulses each program makes, one per lw
	int    exp_reads [MAX_TESTS];

	int cycle_cnt = 0;
	int error_count = 0;
	int seed;

	cpu_core cpu_core_inst (
		.clk(clk),
		.reset_i(reset_i),
		.imem_addr_o(imem_addr),
		.imem_data_i(imem_data),
		.dmem_addr_o(dmem_addr),
		.dmem_wdata_o(dmem_wdata),
		.dmem_we_o(dmem_we),
		.dmem_re_o(dmem_re),
		.dmem_rdata_i(dmem_rdata)
	);

	always #2 clk = ~clk;

	// both memories answer in the same cycle
	// fetches past the program read as nop
	assign imem_data  = (imem_addr[15:4] == '0) ? imem[imem_addr[3:0]] : NOP_WORD;
	assign dmem_rdata = dmem[dmem_addr[7:0]];

	////////////////////////////////////////////////////////////////////////////
	// instruction encoders following the isa field layout

	function automatic word_t enc_addiu(input reg_idx_t rx, input logic [7:0] imm);
		return {5'b01001, rx, imm};
	endfunction

	function automatic word_t enc_beqz(input reg_idx_t rx, input logic [7:0] off);
		return {5'b00100, rx, off};
	endfunction

	function automatic word_t enc_b(input logic [10:0] off);
		return {5'b00010, off};
	endfunction

	function automatic word_t enc_lw(input reg_idx_t rx, input reg_idx_t ry,
			input logic [4:0] imm);
		return {5'b10011, rx, ry, imm};
	endfunction

	function automatic word_t enc_sw(input reg_idx_t rx, input reg_idx_t ry,
			input logic [4:0] imm);
		return {5'b11011, rx, ry, imm};
	endfunction

	// rz = rx op ry with fn 01 for addu or 11 for subu
	function automatic word_t enc_rrr(input reg_idx_t rx, input reg_idx_t ry,
			input reg_idx_t rz, input logic [1:0] fn);
		return {5'b11100, rx, ry, rz, fn};
	endfunction

	// rx = rx op ry where fn 01100 selects and and 01101 selects or
	function automatic word_t enc_alu(input reg_idx_t rx, input reg_idx_t ry,
			input logic [4:0] fn);
		return {5'b11101, rx, ry, fn};
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// failure and compare

	task automatic abort_run(input string reason);
		error_count++;
		$display("%s", reason);
		$display("Some tests failed");
		$fatal(1, "simulation stopped at the first failure");
	endtask

	task automatic check_addr(input string name, input word_t exp, input word_t act);
		if (act !== exp) begin
			abort_run($sformatf("Error: %s store address expected %h actual %h",
				name, exp, act));
		end
	endtask

	task automatic check_word(input string name, input word_t exp, input word_t act);
		if (act !== exp) begin
			abort_run($sformatf("Error: %s store data expected %h actual %h",
				name, exp, act));
		end
	endtask

	task automatic check_count(input string name, input int exp, input int act);
		if (act != exp) begin
			abort_run($sformatf("Error: %s load strobes expected %0d actual %0d",
				name, exp, act));
		end
	endtask

	// runaway guard over the whole run
	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt == CYCLE_LIMIT) begin
			abort_run($sformatf("Timeout: run exceeded %0d clock cycles", CYCLE_LIMIT));
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// table construction

	task automatic emit(input int t, input word_t w);
		prog[t][prog_len[t]] = w;
		prog_len[t]++;
	endtask

	task automatic expect_store(input int t, input word_t addr, input word_t data);
		exp_addr[t][exp_cnt[t]] = addr;
		exp_data[t][exp_cnt[t]] = data;
		exp_cnt[t]++;
	endtask

	task automatic build_table();
		logic [7:0] imm;
		word_t      acc;
		for (int t = 0; t < MAX_TESTS; t++) begin
			prog_len[t]  = 0;
			exp_cnt[t]   = 0;
			exp_reads[t] = 0;
			for (int i = 0; i < PROG_WORDS; i++) begin
				prog[t][i] = NOP_WORD;
			end
		end
		// r1=5-3, r2=7, r3=r1+r2 via memwb and exmem, r4=r1-r3 wraps
		test_name[0] = "fwd_chain";
		emit(0, enc_addiu(3'd1, 8'd5));
		emit(0, enc_addiu(3'd1, 8'hFD));
		emit(0, enc_addiu(3'd2, 8'd7));
		emit(0, enc_rrr(3'd1, 3'd2, 3'd3, 2'b01));
		emit(0, enc_rrr(3'd1, 3'd3, 3'd4, 2'b11));
		emit(0, enc_sw(3'd0, 3'd3, 5'd1));
		emit(0, enc_sw(3'd0, 3'd4, 5'd2));
		emit(0, enc_b(11'h7FF));
		expect_store(0, 16'd1, 16'd2 + 16'd7);
		expect_store(0, 16'd2, 16'd2 - 16'd9);
		// and / or against a sign-extended mask
		test_name[1] = "and_or";
		emit(1, enc_addiu(3'd1, 8'h5A));
		emit(1, enc_addiu(3'd3, 8'h5A));
		emit(1, enc_addiu(3'd2, 8'hF0));
		emit(1, enc_alu(3'd1, 3'd2, 5'b01100));
		emit(1, enc_alu(3'd3, 3'd2, 5'b01101));
		emit(1, enc_sw(3'd0, 3'd1, 5'd4));
		emit(1, enc_sw(3'd0, 3'd3, 5'd5));
		emit(1, enc_b(11'h7FF));
		expect_store(1, 16'd4, 16'h005A & 16'hFFF0);
		expect_store(1, 16'd5, 16'h005A | 16'hFFF0);
		// store, load back, use right away
		test_name[2] = "load_use";
		emit(2, enc_addiu(3'd1, 8'h21));
		emit(2, enc_addiu(3'd2, 8'h10));
		emit(2, enc_sw(3'd2, 3'd1, 5'd3));
		emit(2, enc_lw(3'd2, 3'd4, 5'd3));
		emit(2, enc_addiu(3'd4, 8'd5));
		emit(2, enc_sw(3'd2, 3'd4, 5'd4));
		emit(2, enc_b(11'h7FF));
		expect_store(2, 16'h0013, 16'h0021);
		expect_store(2, 16'h0014, 16'h0021 + 16'd5);
		exp_reads[2] = 1;
		// squashed slots hold stores to 6, 7, 9 and 10
		test_name[3] = "beqz_squash";
		emit(3, enc_addiu(3'd1, 8'd1));
		emit(3, enc_addiu(3'd3, 8'h33));
		emit(3, enc_beqz(3'd2, 8'd2));
		emit(3, enc_sw(3'd0, 3'd3, 5'd6));
		emit(3, enc_sw(3'd0, 3'd3, 5'd7));
		emit(3, enc_beqz(3'd1, 8'd2));
		emit(3, enc_sw(3'd0, 3'd1, 5'd8));
		emit(3, enc_addiu(3'd1, 8'hFF));
		emit(3, enc_beqz(3'd1, 8'd2));
		emit(3, enc_sw(3'd0, 3'd3, 5'd9));
		emit(3, enc_sw(3'd0, 3'd3, 5'd10));
		emit(3, enc_sw(3'd0, 3'd3, 5'd11));
		emit(3, enc_b(11'h7FF));
		expect_store(3, 16'd8, 16'd1);
		expect_store(3, 16'd11, 16'h0033);
		// r1 counts 3 down to 0, r2 counts iterations
		test_name[4] = "countdown";
		emit(4, enc_addiu(3'd1, 8'd3));
		emit(4, enc_beqz(3'd1, 8'd3));
		emit(4, enc_addiu(3'd1, 8'hFF));
		emit(4, enc_addiu(3'd2, 8'd1));
		emit(4, enc_b(11'h7FC));
		emit(4, enc_sw(3'd0, 3'd2, 5'd12));
		emit(4, enc_b(11'h7FF));
		expect_store(4, 16'd12, 16'd3);
		// running sum of sign-extended random immediates
		test_name[5] = "rand_addiu";
		seed = 32'h3a8d;
		acc  = '0;
		for (int k = 0; k < MAX_STORES; k++) begin
			imm = 8'($random(seed));
			acc = acc + {{8{imm[7]}}, imm};
			emit(5, enc_addiu(3'd1, imm));
			emit(5, enc_sw(3'd0, 3'd1, 5'(k)));
			expect_store(5, word_t'(k), acc);
		end
		emit(5, enc_b(11'h7FF));
	endtask

	////////////////////////////////////////////////////////////////////////////
	// each test run starts and ends on a falling edge

	task automatic run_test(input int t);
		int seen;
		int idle;
		int reads;
		seen = 0;
		idle = 0;
		reads = 0;
		reset_i = 1'b1;
		for (int i = 0; i < 256; i++) begin
			dmem[i] = '0;
		end
		for (int i = 0; i < PROG_WORDS; i++) begin
			imem[i] = prog[t][i];
		end
		repeat (10) @(posedge clk);
		@(negedge clk);
		reset_i = 1'b0;
		// stores are stable mid-cycle and land in dmem here
		while (seen < exp_cnt[t] || idle < DRAIN) begin
			@(negedge clk);
			if (dmem_re === 1'b1) begin
				reads++;
			end
			if (dmem_we === 1'b1) begin
				if (seen >= exp_cnt[t]) begin
					abort_run($sformatf("test %s made more than the %0d expected stores",
						test_name[t], exp_cnt[t]));
				end
				check_addr(test_name[t], exp_addr[t][seen], dmem_addr);
				check_word(test_name[t], exp_data[t][seen], dmem_wdata);
				dmem[dmem_addr[7:0]] = dmem_wdata;
				seen++;
			end
			if (seen >= exp_cnt[t]) begin
				idle++;
			end
		end
		check_count(test_name[t], exp_reads[t], reads);
	endtask

	initial begin
		reset_i = 1'b1;
		build_table();
		@(negedge clk);
		for (int t = 0; t < N_TESTS; t++) begin
			run_test(t);
		end
		if (error_count == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

//--- sim.f
+incdir+.
isa_pkg.sv
pipe_pkg.sv
pipe_reg.sv
fetch_unit.sv
decode_unit.sv
reg_file.sv
execute_unit.sv
hazard_unit.sv
cpu_core.sv
tb_cpu_core.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the cpu_core testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing -f sim.f --top-module tb_cpu_core \
	-Mdir obj_dir -o tb_cpu_core_sim

# the simulation may exit nonzero on failure; the log decides
./obj_dir/tb_cpu_core_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Some tests failed" sim.log; then
	echo "simulation FAILED"
	exit 1
fi
if ! grep -q "All tests passed" sim.log; then
	echo "simulation ended without a result"
	exit 1
fi
echo "simulation PASSED"
